//--- dv/tube_ula_model.svh
`ifndef TUBE_ULA_MODEL_SVH
`define TUBE_ULA_MODEL_SVH

// Expected channel contents, oldest byte first
logic [7:0]  h2p_q [4][$];
logic [7:0]  p2h_q [4][$];
logic [5:0]  model_flags;
logic [15:0] lfsr_state;

function automatic int h2p_depth(input int n);
    return (n == 2) ? R3_DEPTH : 1;
endfunction

function automatic int p2h_depth(input int n);
    return (n == 0) ? P2H_R1_DEPTH : h2p_depth(n);
endfunction

// Taps 16, 14, 13, 11
function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
endfunction

function automatic logic [7:0] random_byte();
    logic [7:0] b;
    b = '0;
    for (int i = 0; i < 8; i++)
        b = {b[6:0], lfsr_bit()};
    return b;
endfunction

function automatic void apply_ctrl(input logic [7:0] din);
    for (int i = 0; i < 6; i++)
        if (din[i])
            model_flags[i] = din[7];
endfunction

function automatic void flush_model();
    for (int n = 0; n < 4; n++)
    begin
        h2p_q[n].delete();
        p2h_q[n].delete();
    end
endfunction

// Soft reset drops the byte, so does a full channel
function automatic void push_model(input bit to_para, input int n, input logic [7:0] d);
    if (model_flags[tube_pkg::FLAG_T])
        return;
    if (to_para && h2p_q[n].size() < h2p_depth(n))
        h2p_q[n].push_back(d);
    else if (!to_para && p2h_q[n].size() < p2h_depth(n))
        p2h_q[n].push_back(d);
endfunction

function automatic logic [7:0] head_model(input bit to_host, input int n);
    if (to_host)
        return (p2h_q[n].size() != 0) ? p2h_q[n][0] : 8'h00;
    return (h2p_q[n].size() != 0) ? h2p_q[n][0] : 8'h00;
endfunction

function automatic void drop_head(input bit to_host, input int n);
    if (to_host && p2h_q[n].size() != 0)
        p2h_q[n].delete(0);
    else if (!to_host && h2p_q[n].size() != 0)
        h2p_q[n].delete(0);
endfunction

function automatic logic [7:0] expected_status(input bit host_side, input logic [2:0] addr);
    logic [7:0] s;
    int         n;
    n = addr[2:1];
    s = '0;
    if (host_side)
    begin
        s[tube_pkg::STATUS_AVAIL_BIT] = (p2h_q[n].size() != 0);
        s[tube_pkg::STATUS_NFULL_BIT] = (h2p_q[n].size() < h2p_depth(n));
        if (addr == 3'd0)
            s[5:0] = model_flags;
    end
    else
    begin
        s[tube_pkg::STATUS_AVAIL_BIT] = (h2p_q[n].size() != 0);
        s[tube_pkg::STATUS_NFULL_BIT] = (p2h_q[n].size() < p2h_depth(n));
    end
    return s;
endfunction

// Returned as hirq, pirq, pnmi
function automatic logic [2:0] expected_irq();
    logic hi;
    logic pi;
    logic nmi;
    hi  = model_flags[tube_pkg::FLAG_Q] && (p2h_q[3].size() != 0);
    pi  = (model_flags[tube_pkg::FLAG_I] && (h2p_q[0].size() != 0)) ||
          (model_flags[tube_pkg::FLAG_J] && (h2p_q[3].size() != 0));
    nmi = model_flags[tube_pkg::FLAG_M] && (h2p_q[2].size() != 0);
    return {hi, pi, nmi};
endfunction

`endif

//--- dv/tube_ula_tb.sv
`timescale 1ns/10ps

module tube_ula_tb;

    localparam int P2H_R1_DEPTH = 24;
    localparam int R3_DEPTH     = 2;
    localparam int POLL_LIMIT   = 20;

    logic       HO2;
    logic       arst_n;
    logic [2:0] host_addr;
    logic       host_cs_n;
    logic       host_rnw;
    logic [7:0] host_din;
    logic [7:0] host_dout;
    logic       host_doe;
    logic [2:0] para_addr;
    logic       para_cs_n;
    logic       para_rd_n;
    logic       para_wr_n;
    logic [7:0] para_din;
    logic [7:0] para_dout;
    logic       para_doe;
    logic       hirq;
    logic       pirq;
    logic       pnmi;
    logic       prst;
    logic [7:0] last_read;

    `include "tube_ula_model.svh"

    tube_ula #(.P2H_R1_DEPTH(P2H_R1_DEPTH), .R3_DEPTH(R3_DEPTH)) DUT (
        .HO2       (HO2),
        .arst_n    (arst_n),
        .host_addr (host_addr),
        .host_cs_n (host_cs_n),
        .host_rnw  (host_rnw),
        .host_din  (host_din),
        .host_dout (host_dout),
        .host_doe  (host_doe),
        .para_addr (para_addr),
        .para_cs_n (para_cs_n),
        .para_rd_n (para_rd_n),
        .para_wr_n (para_wr_n),
        .para_din  (para_din),
        .para_dout (para_dout),
        .para_doe  (para_doe),
        .hirq      (hirq),
        .pirq      (pirq),
        .pnmi      (pnmi),
        .prst      (prst)
    );

    always #50 HO2 = ~HO2;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp)
        else
            stop_with_error($sformatf("Mismatch at %0t: %s is %02h, expected %02h",
                                      $time, name, got, exp));
    endtask

    // Flush acts on the flags held before this edge
    task automatic clock_edge();
        @(posedge HO2);
        if (model_flags[tube_pkg::FLAG_T])
            flush_model();
    endtask

    task automatic end_access();
        #10;
        host_cs_n = 1'b1;
        host_rnw  = 1'b1;
        para_cs_n = 1'b1;
        para_rd_n = 1'b1;
        para_wr_n = 1'b1;
        clock_edge();
        #10;
    endtask

    task automatic host_write(input logic [2:0] addr, input logic [7:0] data);
        host_addr = addr;
        host_din  = data;
        host_rnw  = 1'b0;
        host_cs_n = 1'b0;
        clock_edge();
        if (addr[0])
            push_model(1'b1, addr[2:1], data);
        else if (addr == 3'd0)
            apply_ctrl(data);
        end_access();
    endtask

    task automatic host_read(input logic [2:0] addr);
        logic [7:0] exp;
        host_addr = addr;
        host_rnw  = 1'b1;
        host_cs_n = 1'b0;
        #80;
        exp = addr[0] ? head_model(1'b1, addr[2:1]) : expected_status(1'b1, addr);
        check_value("host_doe", host_doe, 1'b1);
        check_value("host_dout", host_dout, exp);
        clock_edge();
        if (addr[0])
            drop_head(1'b1, addr[2:1]);
        end_access();
    endtask

    task automatic para_write(input logic [2:0] addr, input logic [7:0] data);
        para_addr = addr;
        para_din  = data;
        para_wr_n = 1'b0;
        para_cs_n = 1'b0;
        clock_edge();
        if (addr[0])
            push_model(1'b0, addr[2:1], data);
        end_access();
    endtask

    task automatic para_read(input logic [2:0] addr);
        logic [7:0] exp;
        para_addr = addr;
        para_rd_n = 1'b0;
        para_cs_n = 1'b0;
        #80;
        exp = addr[0] ? head_model(1'b0, addr[2:1]) : expected_status(1'b0, addr);
        check_value("para_doe", para_doe, 1'b1);
        check_value("para_dout", para_dout, exp);
        clock_edge();
        if (addr[0])
            drop_head(1'b0, addr[2:1]);
        end_access();
    endtask

    // Status read that only records what the parasite sees
    task automatic sample_para_status(input int n);
        para_addr = 3'(2 * n);
        para_rd_n = 1'b0;
        para_cs_n = 1'b0;
        #80;
        last_read = para_dout;
        clock_edge();
        end_access();
    endtask

    // Parasite side polls its status until data shows up
    task automatic wait_para_avail(input int n);
        int tries;
        tries = 0;
        sample_para_status(n);
        while (!last_read[tube_pkg::STATUS_AVAIL_BIT] && tries < POLL_LIMIT)
        begin
            tries++;
            sample_para_status(n);
        end
        if (!last_read[tube_pkg::STATUS_AVAIL_BIT])
            stop_with_error($sformatf("Timeout: register %0d never showed data to the parasite",
                                      n + 1));
        para_read(3'(2 * n));
    endtask

    task automatic read_all_status();
        for (int n = 0; n < 4; n++)
        begin
            host_read(3'(2 * n));
            para_read(3'(2 * n));
        end
    endtask

    // Interrupts, reset pin and idle bus enables, every cycle
    always @(negedge HO2)
    begin : compare
        logic [2:0] irq;
        if (arst_n)
        begin
            irq = expected_irq();
            check_value("hirq", hirq, irq[2]);
            check_value("pirq", pirq, irq[1]);
            check_value("pnmi", pnmi, irq[0]);
            check_value("prst", prst, model_flags[tube_pkg::FLAG_P]);
            if (host_cs_n)
                check_value("host_doe", host_doe, 1'b0);
            if (para_cs_n)
                check_value("para_doe", para_doe, 1'b0);
        end
    end

    initial
    begin
        HO2         = 1'b0;
        arst_n      = 1'b0;
        host_addr   = '0;
        host_cs_n   = 1'b1;
        host_rnw    = 1'b1;
        host_din    = '0;
        para_addr   = '0;
        para_cs_n   = 1'b1;
        para_rd_n   = 1'b1;
        para_wr_n   = 1'b1;
        para_din    = '0;
        last_read   = '0;
        model_flags = '0;
        lfsr_state  = 16'd21777;
        repeat (3) @(posedge HO2);
        #10;
        arst_n = 1'b1;
        read_all_status();

        // Set P, J and I, clear P again, then clear everything
        host_write(3'd0, 8'h96);
        host_read(3'd0);
        host_write(3'd0, 8'h10);
        host_read(3'd0);
        host_write(3'd0, 8'h1F);
        host_read(3'd0);

        // Host to parasite, each register filled to its depth
        for (int n = 0; n < 4; n++)
        begin
            for (int k = 0; k < h2p_depth(n); k++)
                host_write(3'(2 * n + 1), random_byte());
            host_read(3'(2 * n));
            wait_para_avail(n);
            for (int k = 0; k < h2p_depth(n); k++)
                para_read(3'(2 * n + 1));
            host_read(3'(2 * n));
            para_read(3'(2 * n));
        end

        // Parasite to host, one byte too many each time
        for (int n = 0; n < 4; n++)
        begin
            for (int k = 0; k <= p2h_depth(n); k++)
                para_write(3'(2 * n + 1), random_byte());
            host_read(3'(2 * n));
            para_read(3'(2 * n));
            for (int k = 0; k <= p2h_depth(n); k++)
                host_read(3'(2 * n + 1));
            host_read(3'(2 * n));
        end

        // Enable M, J, I and Q, then raise and drop each interrupt
        host_write(3'd0, 8'h8F);
        para_write(3'd7, random_byte());
        host_read(3'd7);
        host_write(3'd1, random_byte());
        para_read(3'd1);
        host_write(3'd7, random_byte());
        host_write(3'd0, 8'h04);
        para_read(3'd7);
        host_write(3'd5, random_byte());
        para_read(3'd5);
        host_write(3'd0, 8'h0F);

        // Soft reset with data waiting in several channels
        host_write(3'd1, random_byte());
        host_write(3'd5, random_byte());
        para_write(3'd1, random_byte());
        para_write(3'd1, random_byte());
        para_write(3'd7, random_byte());
        host_write(3'd0, 8'hA0);
        host_write(3'd3, random_byte());
        para_write(3'd3, random_byte());
        read_all_status();
        host_write(3'd0, 8'h20);
        read_all_status();
        host_write(3'd3, random_byte());
        para_write(3'd3, random_byte());
        para_read(3'd3);
        host_read(3'd3);
        read_all_status();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- source/tube_bus_decode.sv
`timescale 1ns/10ps

module tube_bus_decode
(
    input  logic                          HO2,
    input  logic                          arst_n,
    input  logic [2:0]                    host_addr,
    input  logic                          host_cs_n,
    input  logic                          host_rnw,
    input  logic [2:0]                    para_addr,
    input  logic                          para_cs_n,
    input  logic                          para_rd_n,
    input  logic                          para_wr_n,
    output logic [tube_pkg::NUM_REGS-1:0] h2p_push,
    output logic [tube_pkg::NUM_REGS-1:0] p2h_pop,
    output logic [tube_pkg::NUM_REGS-1:0] p2h_push,
    output logic [tube_pkg::NUM_REGS-1:0] h2p_pop,
    output logic                          ctrl_wr
);

    logic                          host_cs_n_q;
    logic                          para_cs_n_q;
    logic                          host_first;
    logic                          para_first;
    logic [tube_pkg::NUM_REGS-1:0] host_sel;
    logic [tube_pkg::NUM_REGS-1:0] para_sel;

    // Previous chip selects, so a long access counts only once
    always_ff @(posedge HO2 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            host_cs_n_q <= 1'b1;
            para_cs_n_q <= 1'b1;
        end
        else
        begin
            host_cs_n_q <= host_cs_n;
            para_cs_n_q <= para_cs_n;
        end
    end

    assign host_first = !host_cs_n && host_cs_n_q;
    assign para_first = !para_cs_n && para_cs_n_q;

    // Odd addresses select a data port, bits 2:1 pick the register
    always_comb
    begin
        for (int i = 0; i < tube_pkg::NUM_REGS; i++)
        begin
            host_sel[i] = host_addr[0] && (host_addr[2:1] == i);
            para_sel[i] = para_addr[0] && (para_addr[2:1] == i);
        end
    end

    assign h2p_push = (host_first && !host_rnw) ? host_sel : '0;
    assign p2h_pop  = (host_first &&  host_rnw) ? host_sel : '0;
    assign p2h_push = (para_first && !para_wr_n) ? para_sel : '0;
    assign h2p_pop  = (para_first && !para_rd_n) ? para_sel : '0;

    // Control register shares address 0 with register 1 status
    assign ctrl_wr = host_first && !host_rnw && (host_addr == 3'd0);

    // The parasite never strobes read and write together
    a_para_strobes: assert property (@(posedge HO2) disable iff (!arst_n)
        !para_cs_n |-> (para_rd_n || para_wr_n));

endmodule

//--- source/tube_control_reg.sv
`timescale 1ns/10ps

module tube_control_reg
(
    input  logic                           HO2,
    input  logic                           arst_n,
    input  logic                           ctrl_wr,
    input  logic [tube_pkg::DATA_W-1:0]    host_din,
    output logic [tube_pkg::NUM_FLAGS-1:0] flags,
    output logic                           prst
);

    logic [tube_pkg::NUM_FLAGS-1:0] flags_next;

    // Set/clear write: masked flags take the set bit, the rest hold
    always_comb
    begin
        flags_next = flags;
        if (ctrl_wr)
        begin
            for (int i = 0; i < tube_pkg::NUM_FLAGS; i++)
            begin
                if (host_din[i])
                begin
                    flags_next[i] = host_din[tube_pkg::CTRL_SET_BIT];
                end
            end
        end
    end

    always_ff @(posedge HO2 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            flags <= '0;
        end
        else
        begin
            flags <= flags_next;
        end
    end

    // Own flop for the reset pin, in step with flag P
    always_ff @(posedge HO2 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            prst <= 1'b0;
        end
        else
        begin
            prst <= flags_next[tube_pkg::FLAG_P];
        end
    end

endmodule

//--- source/tube_fifo.sv
`timescale 1ns/10ps

module tube_fifo
#(
    parameter int DEPTH = 1
)
(
    input  logic                        HO2,
    input  logic                        arst_n,
    input  logic                        flush,
    input  logic                        push,
    input  logic [tube_pkg::DATA_W-1:0] push_data,
    input  logic                        pop,
    output logic [tube_pkg::DATA_W-1:0] head_data,
    output logic                        avail,
    output logic                        not_full
);

    // A depth of one still needs a one-bit pointer
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

    logic [tube_pkg::DATA_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]            wr_ptr;
    logic [PTR_W-1:0]            rd_ptr;
    logic [CNT_W-1:0]            count;
    logic                        push_ok;
    logic                        pop_ok;

    // Writes to a full FIFO and reads from an empty one do nothing
    assign push_ok = push && not_full && !flush;
    assign pop_ok  = pop && avail && !flush;

    always_ff @(posedge HO2 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else if (flush)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push_ok)
            begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok)
            begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            if (push_ok && !pop_ok)
            begin
                count <= count + 1'b1;
            end
            else if (pop_ok && !push_ok)
            begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge HO2)
    begin
        if (push_ok)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign avail    = (count != '0);
    assign not_full = (count != FULL_CNT);

    // Empty reads return zero
    assign head_data = avail ? mem[rd_ptr] : '0;

    a_count_range: assert property (@(posedge HO2) disable iff (!arst_n)
        count <= FULL_CNT);

    // Soft reset leaves nothing to read
    a_flush_empties: assert property (@(posedge HO2) disable iff (!arst_n)
        flush |=> !avail);

endmodule

//--- source/tube_pkg.sv
package tube_pkg;

    // Byte width of both the host and the parasite data bus
    parameter int DATA_W = 8;

    // Register pairs, each with one FIFO per direction
    parameter int NUM_REGS = 4;

    // Control register flags
    parameter int NUM_FLAGS = 6;

    // Soft reset, flushes every FIFO while set
    parameter int FLAG_T = 5;

    // Parasite reset output
    parameter int FLAG_P = 4;

    // NMI enable, register 3 host to parasite
    parameter int FLAG_M = 3;

    // Parasite IRQ enable, register 4 host to parasite
    parameter int FLAG_J = 2;

    // Parasite IRQ enable, register 1 host to parasite
    parameter int FLAG_I = 1;

    // Host IRQ enable, register 4 parasite to host
    parameter int FLAG_Q = 0;

    // Value given to every flag whose mask bit is set in a control write
    parameter int CTRL_SET_BIT = 7;

    // Status byte layout, as seen from either side
    parameter int STATUS_AVAIL_BIT = 7;
    parameter int STATUS_NFULL_BIT = 6;

endpackage

//--- source/tube_readback.sv
`timescale 1ns/10ps

module tube_readback
(
    input  logic [2:0]                                        host_addr,
    input  logic                                              host_cs_n,
    input  logic                                              host_rnw,
    input  logic [2:0]                                        para_addr,
    input  logic                                              para_cs_n,
    input  logic                                              para_rd_n,
    input  logic [tube_pkg::NUM_FLAGS-1:0]                    flags,
    input  logic [tube_pkg::NUM_REGS-1:0]                     h2p_avail,
    input  logic [tube_pkg::NUM_REGS-1:0]                     h2p_not_full,
    input  logic [tube_pkg::NUM_REGS-1:0][tube_pkg::DATA_W-1:0] h2p_data,
    input  logic [tube_pkg::NUM_REGS-1:0]                     p2h_avail,
    input  logic [tube_pkg::NUM_REGS-1:0]                     p2h_not_full,
    input  logic [tube_pkg::NUM_REGS-1:0][tube_pkg::DATA_W-1:0] p2h_data,
    output logic [tube_pkg::DATA_W-1:0]                       host_dout,
    output logic                                              host_doe,
    output logic [tube_pkg::DATA_W-1:0]                       para_dout,
    output logic                                              para_doe,
    output logic                                              hirq,
    output logic                                              pirq,
    output logic                                              pnmi
);

    logic [1:0]                  host_idx;
    logic [1:0]                  para_idx;
    logic [tube_pkg::DATA_W-1:0] host_status;
    logic [tube_pkg::DATA_W-1:0] para_status;

    assign host_idx = host_addr[2:1];
    assign para_idx = para_addr[2:1];

    // Drive the buses only while a read is in progress
    assign host_doe = !host_cs_n && host_rnw;
    assign para_doe = !para_cs_n && !para_rd_n;

    // Host status: data from the parasite, room towards the parasite
    always_comb
    begin
        host_status = '0;
        host_status[tube_pkg::STATUS_AVAIL_BIT] = p2h_avail[host_idx];
        host_status[tube_pkg::STATUS_NFULL_BIT] = h2p_not_full[host_idx];
        if (host_addr == 3'd0)
        begin
            host_status[tube_pkg::NUM_FLAGS-1:0] = flags;
        end
    end

    // Parasite status is the mirror image
    always_comb
    begin
        para_status = '0;
        para_status[tube_pkg::STATUS_AVAIL_BIT] = h2p_avail[para_idx];
        para_status[tube_pkg::STATUS_NFULL_BIT] = p2h_not_full[para_idx];
    end

    always_comb
    begin
        if (!host_doe)
            host_dout = '0;
        else if (host_addr[0])
            host_dout = p2h_data[host_idx];
        else
            host_dout = host_status;
    end

    always_comb
    begin
        if (!para_doe)
            para_dout = '0;
        else if (para_addr[0])
            para_dout = h2p_data[para_idx];
        else
            para_dout = para_status;
    end

    // Register 4 towards the host raises the host IRQ
    assign hirq = flags[tube_pkg::FLAG_Q] && p2h_avail[3];

    // Registers 1 and 4 towards the parasite share its IRQ
    assign pirq = (flags[tube_pkg::FLAG_I] && h2p_avail[0]) ||
                  (flags[tube_pkg::FLAG_J] && h2p_avail[3]);

    assign pnmi = flags[tube_pkg::FLAG_M] && h2p_avail[2];

endmodule

//--- source/tube_ula.sv
`timescale 1ns/10ps

module tube_ula
#(
    parameter int P2H_R1_DEPTH = 24,
    parameter int R3_DEPTH     = 2
)
(
    input  logic                        HO2,
    input  logic                        arst_n,
    input  logic [2:0]                  host_addr,
    input  logic                        host_cs_n,
    input  logic                        host_rnw,
    input  logic [tube_pkg::DATA_W-1:0] host_din,
    output logic [tube_pkg::DATA_W-1:0] host_dout,
    output logic                        host_doe,
    input  logic [2:0]                  para_addr,
    input  logic                        para_cs_n,
    input  logic                        para_rd_n,
    input  logic                        para_wr_n,
    input  logic [tube_pkg::DATA_W-1:0] para_din,
    output logic [tube_pkg::DATA_W-1:0] para_dout,
    output logic                        para_doe,
    output logic                        hirq,
    output logic                        pirq,
    output logic                        pnmi,
    output logic                        prst
);

    logic [tube_pkg::NUM_REGS-1:0]                        h2p_push;
    logic [tube_pkg::NUM_REGS-1:0]                        h2p_pop;
    logic [tube_pkg::NUM_REGS-1:0]                        p2h_push;
    logic [tube_pkg::NUM_REGS-1:0]                        p2h_pop;
    logic                                                 ctrl_wr;
    logic [tube_pkg::NUM_FLAGS-1:0]                       flags;
    logic [tube_pkg::NUM_REGS-1:0]                        h2p_avail;
    logic [tube_pkg::NUM_REGS-1:0]                        h2p_not_full;
    logic [tube_pkg::NUM_REGS-1:0][tube_pkg::DATA_W-1:0]  h2p_data;
    logic [tube_pkg::NUM_REGS-1:0]                        p2h_avail;
    logic [tube_pkg::NUM_REGS-1:0]                        p2h_not_full;
    logic [tube_pkg::NUM_REGS-1:0][tube_pkg::DATA_W-1:0]  p2h_data;

    tube_bus_decode u_decode (
        .HO2       (HO2),
        .arst_n    (arst_n),
        .host_addr (host_addr),
        .host_cs_n (host_cs_n),
        .host_rnw  (host_rnw),
        .para_addr (para_addr),
        .para_cs_n (para_cs_n),
        .para_rd_n (para_rd_n),
        .para_wr_n (para_wr_n),
        .h2p_push  (h2p_push),
        .p2h_pop   (p2h_pop),
        .p2h_push  (p2h_push),
        .h2p_pop   (h2p_pop),
        .ctrl_wr   (ctrl_wr)
    );

    tube_control_reg u_control (
        .HO2      (HO2),
        .arst_n   (arst_n),
        .ctrl_wr  (ctrl_wr),
        .host_din (host_din),
        .flags    (flags),
        .prst     (prst)
    );

    // Register 1 towards the host is the deep one, register 3 is two bytes
    for (genvar n = 0; n < tube_pkg::NUM_REGS; n++)
    begin : g_reg
        localparam int H2P_DEPTH = (n == 2) ? R3_DEPTH : 1;
        localparam int P2H_DEPTH = (n == 0) ? P2H_R1_DEPTH : H2P_DEPTH;

        tube_fifo #(.DEPTH(H2P_DEPTH)) u_h2p (
            .HO2       (HO2),
            .arst_n    (arst_n),
            .flush     (flags[tube_pkg::FLAG_T]),
            .push      (h2p_push[n]),
            .push_data (host_din),
            .pop       (h2p_pop[n]),
            .head_data (h2p_data[n]),
            .avail     (h2p_avail[n]),
            .not_full  (h2p_not_full[n])
        );

        tube_fifo #(.DEPTH(P2H_DEPTH)) u_p2h (
            .HO2       (HO2),
            .arst_n    (arst_n),
            .flush     (flags[tube_pkg::FLAG_T]),
            .push      (p2h_push[n]),
            .push_data (para_din),
            .pop       (p2h_pop[n]),
            .head_data (p2h_data[n]),
            .avail     (p2h_avail[n]),
            .not_full  (p2h_not_full[n])
        );
    end

    tube_readback u_readback (
        .host_addr    (host_addr),
        .host_cs_n    (host_cs_n),
        .host_rnw     (host_rnw),
        .para_addr    (para_addr),
        .para_cs_n    (para_cs_n),
        .para_rd_n    (para_rd_n),
        .flags        (flags),
        .h2p_avail    (h2p_avail),
        .h2p_not_full (h2p_not_full),
        .h2p_data     (h2p_data),
        .p2h_avail    (p2h_avail),
        .p2h_not_full (p2h_not_full),
        .p2h_data     (p2h_data),
        .host_dout    (host_dout),
        .host_doe     (host_doe),
        .para_dout    (para_dout),
        .para_doe     (para_doe),
        .hirq         (hirq),
        .pirq         (pirq),
        .pnmi         (pnmi)
    );

endmodule

//--- tube_ula.f
+incdir+dv
source/tube_pkg.sv
source/tube_bus_decode.sv
source/tube_control_reg.sv
source/tube_fifo.sv
source/tube_readback.sv
source/tube_ula.sv
dv/tube_ula_tb.sv
